// ==== design/adc_capture.sv ====
//////////////////////////////////////////////////
// adc capture for all channels: ddr pairs back in
// bit order, offset binary to two's complement,
// three register stages, no reset
//////////////////////////////////////////////////

`default_nettype none

module adc_capture
  import adc_front_pkg::*;
(
  input  wire                      adc_clk_01,
  input  adc_word_u   [N_ADC-1:0]  adc_pins_i,  // sampled pin pairs per channel
  output adc_sample_t [N_ADC-1:0]  adc_dat_o    // signed samples, 3 cycles later
);

  adc_word_u   [N_ADC-1:0] adc_word_t;  // stage 1, reg to reg point
  adc_sample_t [N_ADC-1:0] adc_dat_r;   // stage 2, converted

  //////////////////////////////////////////////////
  // stage 1: pair by pair into the word
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk_01) begin
    for (int ch = 0; ch < N_ADC; ch++) begin
      for (int k = 0; k < ADC_PAIRS; k++) begin
        adc_word_t[ch].pins[k][0] <= adc_pins_i[ch].pins[k][0];  // falling edge bit
        adc_word_t[ch].pins[k][1] <= adc_pins_i[ch].pins[k][1];  // rising edge bit
      end
    end
  end

  //////////////////////////////////////////////////
  // stage 2: negative slope to two's complement
  //////////////////////////////////////////////////

  // keep msb, flip the rest
  always_ff @(posedge adc_clk_01) begin
    for (int ch = 0; ch < N_ADC; ch++) begin
      adc_dat_r[ch] <= {adc_word_t[ch].sample[ADC_W-1],
                        ~adc_word_t[ch].sample[ADC_W-2:0]};
    end
  end

  // stage 3: output register
  always_ff @(posedge adc_clk_01) begin
    adc_dat_o <= adc_dat_r;
  end

endmodule : adc_capture

`default_nettype wire

// ==== design/adc_front_pkg.sv ====
//////////////////////////////////////////////////
// shared widths, register map and ADC word types
// for the adc_clk_01 front end; modules pull it in
// with a wildcard import in their header
//////////////////////////////////////////////////

`default_nettype none

package adc_front_pkg;

  // channel and sample geometry
  localparam int N_ADC     = 4;   // adc channels
  localparam int ADC_W     = 14;  // bits per sample
  localparam int ADC_PAIRS = 7;   // ddr pin pairs per sample

  // expansion connector
  localparam int EXP_W = 11;

  // pdm outputs
  localparam int PDM_W     = 8;
  localparam int PDM_RANGE = 255;  // pdm period in cycles

  // reset stretch after pll lock
  localparam int RST_MAX   = 64;
  localparam int RST_CNT_W = $clog2(RST_MAX + 1);

  //////////////////////////////////////////////////
  // system bus and register map
  //////////////////////////////////////////////////

  localparam int BUS_AW = 8;
  localparam int BUS_DW = 32;

  localparam logic [BUS_AW-1:0] REG_PDM     = 8'h00;  // 4 pdm levels, ch0 low byte
  localparam logic [BUS_AW-1:0] REG_MODE    = 8'h04;  // [0] trig src asg, [1] alt pin0
  localparam logic [BUS_AW-1:0] REG_EXP_OUT = 8'h08;  // expansion output data
  localparam logic [BUS_AW-1:0] REG_EXP_DIR = 8'h0C;  // 1 = output
  localparam logic [BUS_AW-1:0] REG_EXP_IN  = 8'h10;  // read only, pin state

  // two's complement sample after conversion
  typedef logic signed [ADC_W-1:0] adc_sample_t;

  // one adc word, seen as ddr pairs or as the raw offset binary value
  // pair k sits on bits 2k (falling edge) and 2k+1 (rising edge)
  typedef union packed {
    logic [ADC_PAIRS-1:0][1:0] pins;    // [k][0] falling, [k][1] rising
    logic [ADC_W-1:0]          sample;  // negative slope offset binary
  } adc_word_u;

endpackage : adc_front_pkg

`default_nettype wire

// ==== design/adc_front_top.sv ====
//////////////////////////////////////////////////
// adc_clk_01 front end top: reset sequencing,
// adc capture, register block, pdm outputs and
// expansion pin mux, wired together
//////////////////////////////////////////////////

`default_nettype none

module adc_front_top
  import adc_front_pkg::*;
(
  input  wire                      adc_clk_01,
  input  wire                      rst_i,
  input  wire                      spi_done_i,
  input  wire                      pll_locked_i,
  // adc
  input  adc_word_u   [N_ADC-1:0]  adc_pins_i,
  output adc_sample_t [N_ADC-1:0]  adc_dat_o,
  output logic                     ready_o,
  // system bus
  input  wire  [BUS_AW-1:0]        bus_addr_i,
  input  wire  [BUS_DW-1:0]        bus_wdata_i,
  input  wire                      bus_wen_i,
  input  wire                      bus_ren_i,
  output logic [BUS_DW-1:0]        bus_rdata_o,
  output logic                     bus_ack_o,
  output logic                     bus_err_o,
  // pdm
  output logic [N_ADC-1:0]         dac_pwm_o,
  // expansion connector and triggers
  input  wire  [EXP_W-1:0]         exp_i,
  output logic [EXP_W-1:0]         exp_o,
  output logic [EXP_W-1:0]         exp_oe_o,
  input  wire                      trig_scope_i,
  input  wire                      trig_asg_i
);

  logic                        front_rst;     // domain reset
  logic [N_ADC-1:0][PDM_W-1:0] pdm_level;
  logic                        trig_sel_asg;
  logic                        alt_pin0;
  logic [EXP_W-1:0]            exp_out;
  logic [EXP_W-1:0]            exp_dir;
  logic [EXP_W-1:0]            exp_in;        // synced pins for readback

  //////////////////////////////////////////////////
  // reset and capture
  //////////////////////////////////////////////////

  adc_reset_seq i_rst_seq (
    .adc_clk_01   (adc_clk_01  ),
    .rst_i        (rst_i       ),
    .spi_done_i   (spi_done_i  ),
    .pll_locked_i (pll_locked_i),
    .front_rst_o  (front_rst   ),
    .ready_o      (ready_o     )
  );

  adc_capture i_capture (
    .adc_clk_01 (adc_clk_01),
    .adc_pins_i (adc_pins_i),
    .adc_dat_o  (adc_dat_o )   // 3 cycle latency
  );

  //////////////////////////////////////////////////
  // control, pdm and pins
  //////////////////////////////////////////////////

  ctrl_regs i_regs (
    .adc_clk_01     (adc_clk_01  ),
    .front_rst_i    (front_rst   ),
    .bus_addr_i     (bus_addr_i  ),
    .bus_wdata_i    (bus_wdata_i ),
    .bus_wen_i      (bus_wen_i   ),
    .bus_ren_i      (bus_ren_i   ),
    .bus_rdata_o    (bus_rdata_o ),
    .bus_ack_o      (bus_ack_o   ),
    .bus_err_o      (bus_err_o   ),
    .exp_in_i       (exp_in      ),
    .pdm_level_o    (pdm_level   ),
    .trig_sel_asg_o (trig_sel_asg),
    .alt_pin0_o     (alt_pin0    ),
    .exp_out_o      (exp_out     ),
    .exp_dir_o      (exp_dir     )
  );

  pdm_gen i_pdm (
    .adc_clk_01  (adc_clk_01),
    .front_rst_i (front_rst ),
    .pdm_level_i (pdm_level ),
    .pdm_o       (dac_pwm_o )
  );

  exp_pin_mux i_pin_mux (
    .adc_clk_01     (adc_clk_01  ),
    .front_rst_i    (front_rst   ),
    .exp_i          (exp_i       ),
    .exp_out_i      (exp_out     ),
    .exp_dir_i      (exp_dir     ),
    .alt_pin0_i     (alt_pin0    ),
    .trig_sel_asg_i (trig_sel_asg),
    .trig_scope_i   (trig_scope_i),
    .trig_asg_i     (trig_asg_i  ),
    .exp_o          (exp_o       ),
    .exp_oe_o       (exp_oe_o    ),
    .exp_in_o       (exp_in      )
  );

endmodule : adc_front_top

`default_nettype wire

// ==== design/adc_reset_seq.sv ====
//////////////////////////////////////////////////
// domain reset for adc_clk_01: waits for spi done
// and holds reset for RST_MAX cycles after each
// rising edge of pll lock
//////////////////////////////////////////////////

`default_nettype none

module adc_reset_seq
  import adc_front_pkg::*;
(
  input  wire  adc_clk_01,
  input  wire  rst_i,         // board reset, sync, active high
  input  wire  spi_done_i,    // adc configured, other domain
  input  wire  pll_locked_i,  // pll lock status
  output logic front_rst_o,   // reset for the whole front end
  output logic ready_o        // domain out of reset
);

  logic                 spi_done_meta;  // first sync stage
  logic                 spi_done_sync;  // second sync stage
  logic                 lock_r;         // lock delayed one cycle
  logic                 lock_rise;
  logic [RST_CNT_W-1:0] rst_cnt;        // stretch counter

  // spi done comes from another clock, two flops
  always_ff @(posedge adc_clk_01) begin
    spi_done_meta <= spi_done_i;
    spi_done_sync <= spi_done_meta;
  end

  //////////////////////////////////////////////////
  // lock edge and stretch
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk_01) begin
    lock_r <= pll_locked_i;  // tracks input, also during reset
  end

  assign lock_rise = pll_locked_i & ~lock_r;

  // counts 1..RST_MAX after a lock edge, then back to idle
  always_ff @(posedge adc_clk_01) begin
    if (rst_i) begin
      rst_cnt <= '0;
    end else if (!pll_locked_i) begin
      rst_cnt <= '0;              // lost lock, wait for next edge
    end else if (lock_rise || rst_cnt != '0) begin
      if (rst_cnt < RST_CNT_W'(RST_MAX))
        rst_cnt <= rst_cnt + 1'b1;
      else
        rst_cnt <= '0;            // stretch done
    end
  end

  // registered combine, edge term makes the hold start at once
  always_ff @(posedge adc_clk_01) begin
    front_rst_o <= rst_i | ~spi_done_sync | lock_rise | (rst_cnt != '0);
  end

  assign ready_o = ~front_rst_o;

endmodule : adc_reset_seq

`default_nettype wire

// ==== design/ctrl_regs.sv ====
//////////////////////////////////////////////////
// system bus register block: pdm levels, trigger
// mode and expansion pin control; ack one cycle
// after each request, error on bad access
//////////////////////////////////////////////////

`default_nettype none

module ctrl_regs
  import adc_front_pkg::*;
(
  input  wire                          adc_clk_01,
  input  wire                          front_rst_i,
  // system bus
  input  wire  [BUS_AW-1:0]            bus_addr_i,
  input  wire  [BUS_DW-1:0]            bus_wdata_i,
  input  wire                          bus_wen_i,
  input  wire                          bus_ren_i,
  output logic [BUS_DW-1:0]            bus_rdata_o,
  output logic                         bus_ack_o,
  output logic                         bus_err_o,
  // pin state back from the mux
  input  wire  [EXP_W-1:0]             exp_in_i,
  // configuration
  output logic [N_ADC-1:0][PDM_W-1:0]  pdm_level_o,
  output logic                         trig_sel_asg_o,  // 1 asg, 0 scope
  output logic                         alt_pin0_o,      // trigger onto pin 0
  output logic [EXP_W-1:0]             exp_out_o,
  output logic [EXP_W-1:0]             exp_dir_o        // 1 = output
);

  logic              req;       // any access this cycle
  logic              addr_ok;   // address is in the map
  logic              bad_acc;   // gets an error ack
  logic [BUS_DW-1:0] rd_mux;

  //////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////

  assign req     = bus_wen_i | bus_ren_i;
  assign addr_ok = bus_addr_i inside {REG_PDM, REG_MODE, REG_EXP_OUT,
                                      REG_EXP_DIR, REG_EXP_IN};
  assign bad_acc = ~addr_ok | (bus_wen_i & (bus_addr_i == REG_EXP_IN));

  // read data, zero extended
  always_comb begin
    rd_mux = '0;
    case (bus_addr_i)
      REG_PDM:     rd_mux = pdm_level_o;
      REG_MODE:    rd_mux[1:0] = {alt_pin0_o, trig_sel_asg_o};
      REG_EXP_OUT: rd_mux[EXP_W-1:0] = exp_out_o;
      REG_EXP_DIR: rd_mux[EXP_W-1:0] = exp_dir_o;
      REG_EXP_IN:  rd_mux[EXP_W-1:0] = exp_in_i;
      default:     rd_mux = '0;  // unmapped, err flags it
    endcase
  end

  //////////////////////////////////////////////////
  // registers and handshake
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk_01) begin
    if (front_rst_i) begin
      bus_ack_o      <= 1'b0;
      bus_err_o      <= 1'b0;
      pdm_level_o    <= '0;
      trig_sel_asg_o <= 1'b0;
      alt_pin0_o     <= 1'b0;
      exp_out_o      <= '0;
      exp_dir_o      <= '0;     // all pins input
    end else begin
      bus_ack_o <= req;           // fixed one cycle latency
      bus_err_o <= req & bad_acc;
      if (bus_wen_i) begin
        case (bus_addr_i)
          REG_PDM: pdm_level_o <= bus_wdata_i;  // ch0 in low byte
          REG_MODE: begin
            trig_sel_asg_o <= bus_wdata_i[0];
            alt_pin0_o     <= bus_wdata_i[1];
          end
          REG_EXP_OUT: exp_out_o <= bus_wdata_i[EXP_W-1:0];
          REG_EXP_DIR: exp_dir_o <= bus_wdata_i[EXP_W-1:0];
          default: ;                            // read only or unmapped
        endcase
      end
    end
  end

  // captured on the read, held until the next one
  always_ff @(posedge adc_clk_01) begin
    if (bus_ren_i)
      bus_rdata_o <= rd_mux;
  end

endmodule : ctrl_regs

`default_nettype wire

// ==== design/exp_pin_mux.sv ====
//////////////////////////////////////////////////
// expansion pin mux: registers drive the pins,
// pin 0 can carry the selected trigger instead;
// pin inputs synchronized back for the bus
//////////////////////////////////////////////////

`default_nettype none

module exp_pin_mux
  import adc_front_pkg::*;
(
  input  wire              adc_clk_01,
  input  wire              front_rst_i,
  input  wire  [EXP_W-1:0] exp_i,           // pin state from the pads
  input  wire  [EXP_W-1:0] exp_out_i,       // register output data
  input  wire  [EXP_W-1:0] exp_dir_i,       // register direction
  input  wire              alt_pin0_i,      // alt function on pin 0
  input  wire              trig_sel_asg_i,  // 1 asg, 0 scope
  input  wire              trig_scope_i,
  input  wire              trig_asg_i,
  output logic [EXP_W-1:0] exp_o,
  output logic [EXP_W-1:0] exp_oe_o,        // 1 drives the pin
  output logic [EXP_W-1:0] exp_in_o         // synchronized exp_i
);

  logic             trig_out;  // selected trigger
  logic [EXP_W-1:0] alt_en;    // pins using the alt function
  logic [EXP_W-1:0] alt_dat;   // alt output values
  logic [EXP_W-1:0] exp_meta;

  assign trig_out = trig_sel_asg_i ? trig_asg_i : trig_scope_i;

  // only pin 0 has an alternate function
  assign alt_en  = {{(EXP_W-1){1'b0}}, alt_pin0_i};
  assign alt_dat = {{(EXP_W-1){1'b0}}, trig_out};

  // per pin select, alt forces output enable
  always_ff @(posedge adc_clk_01) begin
    if (front_rst_i) begin
      exp_o    <= '0;
      exp_oe_o <= '0;    // everything input
    end else begin
      exp_o    <= (alt_en & alt_dat) | (~alt_en & exp_out_i);
      exp_oe_o <= alt_en | exp_dir_i;
    end
  end

  // pads are asynchronous to adc_clk_01
  always_ff @(posedge adc_clk_01) begin
    exp_meta <= exp_i;
    exp_in_o <= exp_meta;
  end

endmodule : exp_pin_mux

`default_nettype wire

// ==== design/pdm_gen.sv ====
//////////////////////////////////////////////////
// first order pdm for the slow analog outputs;
// over PDM_RANGE cycles each output is high as
// many times as its level
//////////////////////////////////////////////////

`default_nettype none

module pdm_gen
  import adc_front_pkg::*;
(
  input  wire                          adc_clk_01,
  input  wire                          front_rst_i,
  input  wire  [N_ADC-1:0][PDM_W-1:0]  pdm_level_i,  // duty per channel
  output logic [N_ADC-1:0]             pdm_o         // to the rc filters
);

  localparam logic [PDM_W:0] RANGE = (PDM_W+1)'(PDM_RANGE);

  logic [N_ADC-1:0][PDM_W:0] acc;  // residue, stays below RANGE
  logic [N_ADC-1:0][PDM_W:0] sum;  // residue plus level

  // one spare bit so the sum never wraps
  always_comb begin
    for (int ch = 0; ch < N_ADC; ch++) begin
      sum[ch] = acc[ch] + {1'b0, pdm_level_i[ch]};
    end
  end

  //////////////////////////////////////////////////
  // accumulate and overflow
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk_01) begin
    if (front_rst_i) begin
      acc   <= '0;
      pdm_o <= '0;
    end else begin
      for (int ch = 0; ch < N_ADC; ch++) begin
        if (sum[ch] >= RANGE) begin
          acc[ch]   <= sum[ch] - RANGE;  // wrap
          pdm_o[ch] <= 1'b1;
        end else begin
          acc[ch]   <= sum[ch];
          pdm_o[ch] <= 1'b0;
        end
      end
    end
  end

endmodule : pdm_gen

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the front end testbench with Verilator and run it
# exit status is zero only when the pass line appears in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
  -f tb.f --top-module adc_front_tb -o adc_front_sim \
  && ./obj_dir/adc_front_sim | tee /dev/stderr | grep -F "*** PASSED ***" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== tb.f ====
+incdir+tests
design/adc_front_pkg.sv
design/adc_reset_seq.sv
design/adc_capture.sv
design/ctrl_regs.sv
design/pdm_gen.sv
design/exp_pin_mux.sv
design/adc_front_top.sv
tests/adc_front_tb.sv

// ==== tests/adc_front_checks.svh ====
//////////////////////////////////////////////////
// compare tasks and error counters for the front
// end testbench, included inside its module
//////////////////////////////////////////////////

`ifndef ADC_FRONT_CHECKS_SVH
`define ADC_FRONT_CHECKS_SVH

int check_cnt = 0;  // compares done
int err_cnt   = 0;  // compares failed, timeouts too

// one converted adc sample
task automatic check_sample(input string what, input adc_sample_t got,
                            input adc_sample_t exp);
  check_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("ERROR at %0d ns: %s got %0d expected %0d", $time, what, got, exp);
  end
endtask

// bus response, data only matters when no error is expected
task automatic check_bus(input string what,
                         input logic [BUS_DW-1:0] got_d, input logic got_e,
                         input logic [BUS_DW-1:0] exp_d, input logic exp_e);
  check_cnt++;
  if (got_e !== exp_e) begin
    err_cnt++;
    $display("ERROR at %0d ns: %s err %0b expected %0b", $time, what, got_e, exp_e);
  end else if (!exp_e && got_d !== exp_d) begin
    err_cnt++;
    $display("ERROR at %0d ns: %s data 0x%08h expected 0x%08h",
             $time, what, got_d, exp_d);
  end
endtask

// expansion pin data and output enable
task automatic check_pins(input string what,
                          input logic [EXP_W-1:0] got_o, input logic [EXP_W-1:0] got_oe,
                          input logic [EXP_W-1:0] exp_o, input logic [EXP_W-1:0] exp_oe);
  check_cnt++;
  if (got_o !== exp_o || got_oe !== exp_oe) begin
    err_cnt++;
    $display("ERROR at %0d ns: %s exp_o 0x%03h oe 0x%03h expected 0x%03h oe 0x%03h",
             $time, what, got_o, got_oe, exp_o, exp_oe);
  end
endtask

// cycle counts, lo..hi inclusive
task automatic check_count(input string what, input int got, input int lo, input int hi);
  check_cnt++;
  if (got < lo || got > hi) begin
    err_cnt++;
    $display("ERROR at %0d ns: %s count %0d expected %0d..%0d", $time, what, got, lo, hi);
  end
endtask

`endif

// ==== tests/adc_front_tb.sv ====
//////////////////////////////////////////////////
// testbench for the adc_clk_01 front end: reset
// sequencing, adc capture, then a stimulus table
// for bus registers, pdm outputs and pins
//////////////////////////////////////////////////

`default_nettype none

module adc_front_tb
  import adc_front_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD    = 40;
  localparam int ACK_TIMEOUT   = 8;            // cycles, ack is due after 1
  localparam int READY_TIMEOUT = 4 * RST_MAX;
  localparam int N_WORDS       = 200;          // adc words per channel

  typedef enum logic [2:0] {OP_WR, OP_RD, OP_PDM, OP_PINS, OP_EXPIN} op_e;

  // one table row; pins rows keep oe in [26:16] and data in [10:0] of exp
  typedef struct packed {
    op_e               op;
    logic [BUS_AW-1:0] addr;
    logic [BUS_DW-1:0] data;
    logic [BUS_DW-1:0] exp;
    logic              exp_err;
  } row_t;

  logic                    adc_clk_01;
  logic                    rst_i;
  logic                    spi_done_i;
  logic                    pll_locked_i;
  adc_word_u   [N_ADC-1:0] adc_pins_i;
  adc_sample_t [N_ADC-1:0] adc_dat_o;
  logic                    ready_o;
  logic [BUS_AW-1:0]       bus_addr_i;
  logic [BUS_DW-1:0]       bus_wdata_i;
  logic                    bus_wen_i;
  logic                    bus_ren_i;
  logic [BUS_DW-1:0]       bus_rdata_o;
  logic                    bus_ack_o;
  logic                    bus_err_o;
  logic [N_ADC-1:0]        dac_pwm_o;
  logic [EXP_W-1:0]        exp_i;
  logic [EXP_W-1:0]        exp_o;
  logic [EXP_W-1:0]        exp_oe_o;
  logic                    trig_scope_i;
  logic                    trig_asg_i;

  row_t stim_q[$];       // rows of the current test
  int   test_errs_at = 0;
  int   test_cnt     = 0;
  int   test_fail    = 0;

  `include "adc_front_checks.svh"

  adc_front_top UUT (
    .adc_clk_01   (adc_clk_01  ),
    .rst_i        (rst_i       ),
    .spi_done_i   (spi_done_i  ),
    .pll_locked_i (pll_locked_i),
    .adc_pins_i   (adc_pins_i  ),
    .adc_dat_o    (adc_dat_o   ),
    .ready_o      (ready_o     ),
    .bus_addr_i   (bus_addr_i  ),
    .bus_wdata_i  (bus_wdata_i ),
    .bus_wen_i    (bus_wen_i   ),
    .bus_ren_i    (bus_ren_i   ),
    .bus_rdata_o  (bus_rdata_o ),
    .bus_ack_o    (bus_ack_o   ),
    .bus_err_o    (bus_err_o   ),
    .dac_pwm_o    (dac_pwm_o   ),
    .exp_i        (exp_i       ),
    .exp_o        (exp_o       ),
    .exp_oe_o     (exp_oe_o    ),
    .trig_scope_i (trig_scope_i),
    .trig_asg_i   (trig_asg_i  )
  );

  initial begin
    adc_clk_01 = 1'b0;
    forever #(CLK_PERIOD / 2) adc_clk_01 = ~adc_clk_01;
  end

  //////////////////////////////////////////////////
  // test bookkeeping and bus access
  //////////////////////////////////////////////////

  task automatic begin_test();
    test_errs_at = err_cnt;
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = err_cnt - test_errs_at;
    test_cnt++;
    if (errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      test_fail++;
      $display("test %s: %0d errors", name, errs);
    end
  endtask

  // one request, then wait for the ack at negedges
  task automatic bus_xfer(input logic wr, input logic [BUS_AW-1:0] addr,
                          input logic [BUS_DW-1:0] wdata,
                          output logic [BUS_DW-1:0] rdata, output logic err);
    bit got;
    got   = 1'b0;
    rdata = '0;
    err   = 1'b0;
    @(posedge adc_clk_01);
    bus_addr_i  <= addr;
    bus_wdata_i <= wdata;
    bus_wen_i   <= wr;
    bus_ren_i   <= ~wr;
    @(posedge adc_clk_01);
    bus_wen_i <= 1'b0;                    // single cycle strobe
    bus_ren_i <= 1'b0;
    for (int i = 0; i < ACK_TIMEOUT && !got; i++) begin
      @(negedge adc_clk_01);
      if (bus_ack_o) begin
        got   = 1'b1;
        rdata = bus_rdata_o;
        err   = bus_err_o;
      end
    end
    if (!got) begin
      err_cnt++;
      $display("bus timeout: no ack within %0d cycles for address 0x%02h", ACK_TIMEOUT, addr);
    end
  endtask

  // negedges with ready_o != level before it reaches level
  task automatic wait_ready(input logic level, input string what, output int cycles);
    bit seen;
    seen   = 1'b0;
    cycles = 0;
    for (int i = 0; i < READY_TIMEOUT && !seen; i++) begin
      @(negedge adc_clk_01);
      if (ready_o == level)
        seen = 1'b1;
      else
        cycles++;
    end
    if (!seen) begin
      err_cnt++;
      $display("ready timeout: ready_o never became %0b within %0d cycles (%s)",
               level, READY_TIMEOUT, what);
    end
  endtask

  //////////////////////////////////////////////////
  // reset sequencing and adc capture
  //////////////////////////////////////////////////

  task automatic test_reset();
    int high_cnt;
    int n;
    begin_test();
    high_cnt = 0;
    repeat (20) begin                     // spi done still low
      @(negedge adc_clk_01);
      if (ready_o)
        high_cnt++;
    end
    check_count("ready high while spi done low", high_cnt, 0, 0);
    @(posedge adc_clk_01);
    spi_done_i <= 1'b1;
    wait_ready(1'b1, "after spi done", n);
    @(posedge adc_clk_01);
    pll_locked_i <= 1'b0;                 // lose lock a few cycles
    repeat (4) @(posedge adc_clk_01);
    pll_locked_i <= 1'b1;
    wait_ready(1'b0, "lock edge", n);
    wait_ready(1'b1, "end of stretch", n);
    check_count("ready low after lock edge", n + 1, RST_MAX, RST_MAX + 1);
    finish_test("reset sequencing");
  endtask

  // random pairs in, expected sample 3 cycles later
  task automatic test_capture(input int n_words);
    adc_sample_t [N_ADC-1:0] exp_q[$];
    adc_sample_t [N_ADC-1:0] exp_now;
    adc_sample_t [N_ADC-1:0] exp_old;
    logic [ADC_W-1:0]        word;
    logic [1:0]              pair;
    begin_test();
    for (int c = 0; c < n_words + 3; c++) begin
      @(posedge adc_clk_01);
      if (c < n_words) begin
        for (int ch = 0; ch < N_ADC; ch++) begin
          for (int k = 0; k < ADC_PAIRS; k++) begin
            pair = 2'($urandom);
            adc_pins_i[ch].pins[k] <= pair;  // [1] rising, [0] falling
            word[2*k]   = pair[0];
            word[2*k+1] = pair[1];
          end
          // negative slope around mid scale, code 0 is full positive
          exp_now[ch] = adc_sample_t'((1 << (ADC_W-1)) - 1 - int'(word));
        end
        exp_q.push_back(exp_now);
      end
      @(negedge adc_clk_01);
      if (c >= 3) begin
        exp_old = exp_q.pop_front();
        for (int ch = 0; ch < N_ADC; ch++)
          check_sample($sformatf("ch%0d word %0d", ch, c - 3), adc_dat_o[ch], exp_old[ch]);
      end
    end
    finish_test("adc capture");
  endtask

  //////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////

  task automatic add_row(input op_e op, input logic [BUS_AW-1:0] addr,
                         input logic [BUS_DW-1:0] data, input logic [BUS_DW-1:0] exp,
                         input logic exp_err);
    row_t r;
    r.op      = op;
    r.addr    = addr;
    r.data    = data;
    r.exp     = exp;
    r.exp_err = exp_err;
    stim_q.push_back(r);
  endtask

  function automatic logic [BUS_DW-1:0] pins_exp(input logic [EXP_W-1:0] oe,
                                                 input logic [EXP_W-1:0] o);
    return (BUS_DW'(oe) << 16) | BUS_DW'(o);
  endfunction

  task automatic fill_reg_rows();
    add_row(OP_WR, REG_PDM,     32'h8040_2010, '0,            1'b0);
    add_row(OP_RD, REG_PDM,     '0,            32'h8040_2010, 1'b0);
    add_row(OP_WR, REG_MODE,    32'hFFFF_FFFF, '0,            1'b0);
    add_row(OP_RD, REG_MODE,    '0,            32'h0000_0003, 1'b0);  // two bits only
    add_row(OP_WR, REG_EXP_OUT, 32'hFFFF_F5A5, '0,            1'b0);
    add_row(OP_RD, REG_EXP_OUT, '0,            32'h0000_05A5, 1'b0);
    add_row(OP_WR, REG_EXP_DIR, 32'h0000_0F0F, '0,            1'b0);
    add_row(OP_RD, REG_EXP_DIR, '0,            32'h0000_070F, 1'b0);
    add_row(OP_RD, 8'h14,       '0,            '0,            1'b1);  // unmapped
    add_row(OP_RD, 8'hFC,       '0,            '0,            1'b1);
    add_row(OP_WR, 8'h40,       32'h1234_5678, '0,            1'b1);
    add_row(OP_WR, REG_EXP_IN,  32'h0000_07FF, '0,            1'b1);  // read only
    add_row(OP_RD, REG_PDM,     '0,            32'h8040_2010, 1'b0);  // untouched
  endtask

  task automatic fill_pdm_rows();
    add_row(OP_PDM, REG_PDM, 32'hFF80_0100, '0, 1'b0);  // 0, 1, 128, 255
    add_row(OP_PDM, REG_PDM, 32'h40C0_207F, '0, 1'b0);
  endtask

  // trigger row data: bit 0 scope, bit 1 asg
  task automatic fill_pin_rows();
    add_row(OP_WR,    REG_MODE,    32'h0,   '0,                       1'b0);
    add_row(OP_WR,    REG_EXP_OUT, 32'h2AA, '0,                       1'b0);
    add_row(OP_WR,    REG_EXP_DIR, 32'h0F0, '0,                       1'b0);
    add_row(OP_PINS,  '0,          32'h3,   pins_exp(11'h0F0, 11'h2AA), 1'b0);
    add_row(OP_WR,    REG_MODE,    32'h2,   '0,                       1'b0);  // alt, scope
    add_row(OP_PINS,  '0,          32'h1,   pins_exp(11'h0F1, 11'h2AB), 1'b0);
    add_row(OP_PINS,  '0,          32'h2,   pins_exp(11'h0F1, 11'h2AA), 1'b0);
    add_row(OP_WR,    REG_MODE,    32'h3,   '0,                       1'b0);  // alt, asg
    add_row(OP_PINS,  '0,          32'h2,   pins_exp(11'h0F1, 11'h2AB), 1'b0);
    add_row(OP_PINS,  '0,          32'h1,   pins_exp(11'h0F1, 11'h2AA), 1'b0);
    add_row(OP_WR,    REG_EXP_OUT, 32'h555, '0,                       1'b0);
    add_row(OP_WR,    REG_MODE,    32'h2,   '0,                       1'b0);
    add_row(OP_PINS,  '0,          32'h0,   pins_exp(11'h0F1, 11'h554), 1'b0);
    add_row(OP_EXPIN, REG_EXP_IN,  32'h3C5, 32'h3C5,                  1'b0);
    add_row(OP_EXPIN, REG_EXP_IN,  32'h412, 32'h412,                  1'b0);
  endtask

  task automatic run_table(input string name);
    row_t              r;
    logic [BUS_DW-1:0] rdata;
    logic              err;
    int                hi_cnt[N_ADC];
    begin_test();
    foreach (stim_q[i]) begin
      r = stim_q[i];
      case (r.op)
        OP_WR: begin
          bus_xfer(1'b1, r.addr, r.data, rdata, err);
          check_bus($sformatf("write 0x%02h", r.addr), '0, err, '0, r.exp_err);
        end
        OP_RD: begin
          bus_xfer(1'b0, r.addr, '0, rdata, err);
          check_bus($sformatf("read 0x%02h", r.addr), rdata, err, r.exp, r.exp_err);
        end
        OP_PDM: begin
          bus_xfer(1'b1, REG_PDM, r.data, rdata, err);
          check_bus("write pdm levels", '0, err, '0, 1'b0);
          repeat (2) @(posedge adc_clk_01);  // new level reaches the modulator
          for (int ch = 0; ch < N_ADC; ch++)
            hi_cnt[ch] = 0;
          repeat (PDM_RANGE) begin
            @(negedge adc_clk_01);
            for (int ch = 0; ch < N_ADC; ch++)
              if (dac_pwm_o[ch])
                hi_cnt[ch]++;
          end
          for (int ch = 0; ch < N_ADC; ch++)
            check_count($sformatf("pdm ch%0d high cycles", ch), hi_cnt[ch],
                        int'(r.data[ch*PDM_W +: PDM_W]), int'(r.data[ch*PDM_W +: PDM_W]));
        end
        OP_PINS: begin
          @(posedge adc_clk_01);
          trig_scope_i <= r.data[0];
          trig_asg_i   <= r.data[1];
          @(posedge adc_clk_01);             // mux output register
          @(negedge adc_clk_01);
          check_pins($sformatf("pins, triggers %02b", r.data[1:0]), exp_o, exp_oe_o,
                     r.exp[EXP_W-1:0], r.exp[16 +: EXP_W]);
        end
        default: begin                       // OP_EXPIN
          @(posedge adc_clk_01);
          exp_i <= r.data[EXP_W-1:0];
          repeat (4) @(posedge adc_clk_01);  // through the synchronizer
          bus_xfer(1'b0, REG_EXP_IN, '0, rdata, err);
          check_bus("read exp_in", rdata, err, r.exp, r.exp_err);
        end
      endcase
    end
    stim_q.delete();
    finish_test(name);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(34));
    rst_i        = 1'b1;
    spi_done_i   = 1'b0;
    pll_locked_i = 1'b1;                     // lock stable from the start
    adc_pins_i   = '0;
    bus_addr_i   = '0;
    bus_wdata_i  = '0;
    bus_wen_i    = 1'b0;
    bus_ren_i    = 1'b0;
    exp_i        = '0;
    trig_scope_i = 1'b0;
    trig_asg_i   = 1'b0;
    repeat (10) @(posedge adc_clk_01);
    rst_i <= 1'b0;

    test_reset();
    test_capture(N_WORDS);
    fill_reg_rows();
    run_table("register bus");
    fill_pdm_rows();
    run_table("pdm output");
    fill_pin_rows();
    run_table("expansion pins");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             test_cnt, test_fail, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule : adc_front_tb

`default_nettype wire
